//--- Makefile
# Verilator build and run for tb_conv_top

SIM := obj_dir/Vtb_conv_top

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): project.f design/*.sv tests/tb_conv_top.sv
	verilator --binary --timing -Wno-fatal --top-module tb_conv_top -f project.f

run: $(SIM)
	./$(SIM) | tee /dev/stderr | grep -q "^TEST PASS$$"

clean:
	rm -rf obj_dir

//--- design/cbr_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module cbr_ctrl (
  input  wire             clk_40M,
  input  wire             rst_n,
  input  wire             start,
  output logic            busy,
  output logic            done,
  cbr_wb_if.master        bus,
  output logic            param_step,
  output logic            tap_step,
  output logic            out_step,
  output logic            addr_sel,
  output logic            param_load,
  output logic [3:0]      param_idx,
  output logic            tap_valid,
  output logic            acc_clear,
  output logic            result_take,
  input  wire             param_last,
  input  wire             tap_last,
  input  wire             out_last,
  input  wire cbr_pkg::addr_t rd_addr,
  input  wire cbr_pkg::addr_t wr_addr,
  input  wire cbr_pkg::pix_t  result
);
  import cbr_pkg::*;

  ctrl_state_t state;
  ctrl_state_t state_nxt;
  logic        req;        // access in flight, drives cyc/stb
  logic        acked;      // our access completes this cycle
  logic        bus_state;  // states that talk to memory

  assign acked     = req & bus.ack;
  assign bus_state = (state == LOAD_PARAM) || (state == READ_WIN) ||
                     (state == WRITE_OUT);

  ////////////////////////////////////////////////////////////////////////////
  // sequencing
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_nxt = state;
    case (state)
      IDLE: begin
        if (start) state_nxt = LOAD_PARAM;  // start only seen here
      end
      LOAD_PARAM: begin
        if (acked && param_last) state_nxt = READ_WIN;  // bias was the last one
      end
      READ_WIN: begin
        if (acked && tap_last) state_nxt = ACCUM_WAIT;
      end
      ACCUM_WAIT: begin
        state_nxt = WRITE_OUT;  // single cycle
      end
      WRITE_OUT: begin
        if (acked) state_nxt = out_last ? FINISH : READ_WIN;
      end
      FINISH: begin
        state_nxt = IDLE;
      end
      default: begin
        state_nxt = IDLE;
      end
    endcase
  end

  // req drops in the cycle after ack, so there is always an idle gap
  always_ff @(posedge clk_40M or negedge rst_n) begin
    if (!rst_n) begin
      state <= IDLE;
      req   <= 1'b0;
    end else begin
      state <= state_nxt;
      if (acked) begin
        req <= 1'b0;
      end else if (bus_state && !req) begin
        req <= 1'b1;  // adr already stable from the counters
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // bus and strobes
  ////////////////////////////////////////////////////////////////////////////

  assign bus.cyc   = req;
  assign bus.stb   = req;
  assign bus.we    = req && (state == WRITE_OUT);
  assign bus.adr   = (state == WRITE_OUT) ? wr_addr : rd_addr;
  assign bus.dat_w = result;  // held by mac through WRITE_OUT

  assign addr_sel    = (state != LOAD_PARAM);
  assign param_load  = acked && (state == LOAD_PARAM);
  assign param_step  = param_load;
  assign param_idx   = 4'(rd_addr - WGT_BASE);  // offset into param block
  assign tap_valid   = acked && (state == READ_WIN);  // dat_r valid now
  assign tap_step    = tap_valid;
  assign out_step    = acked && (state == WRITE_OUT);
  assign acc_clear   = out_step || ((state == IDLE) && start);  // fresh window
  assign result_take = (state == ACCUM_WAIT);

  // busy drops in the done cycle
  assign busy = (state != IDLE) && (state != FINISH);
  assign done = (state == FINISH);

endmodule

`default_nettype wire

//--- design/cbr_mac.sv
`timescale 1ns/1ps
`default_nettype none

module cbr_mac #(
  parameter int SHIFT = 4
) (
  input  wire                clk_40M,
  input  wire                rst_n,
  input  wire                param_load,   // store dat_r at param_idx
  input  wire [3:0]          param_idx,
  input  wire                tap_valid,    // pixel on dat_r
  input  wire                acc_clear,
  input  wire                result_take,  // latch requantized result
  input  wire cbr_pkg::pix_t dat_r,
  output cbr_pkg::pix_t      result
);
  import cbr_pkg::*;

  wgt_t       wgt [N_TAPS];  // kernel, row-major
  wgt_t       bias;
  logic [3:0] tap;           // which weight goes with the next pixel
  acc_t       acc;
  acc_t       prod;
  acc_t       biased;
  acc_t       scaled;
  pix_t       clamped;

  ////////////////////////////////////////////////////////////////////////////
  // parameter store
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_40M) begin
    if (param_load) begin
      if (param_idx == 4'(BIAS_ADDR - WGT_BASE)) begin
        bias <= wgt_t'(dat_r);
      end else begin
        wgt[param_idx] <= wgt_t'(dat_r);  // byte reinterpreted as signed
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // multiply-accumulate
  ////////////////////////////////////////////////////////////////////////////

  // pixel zero-extended before the signed multiply
  assign prod = acc_t'(wgt[tap]) * acc_t'($signed({1'b0, dat_r}));

  always_ff @(posedge clk_40M or negedge rst_n) begin
    if (!rst_n) begin
      tap <= '0;
      acc <= '0;
    end else if (acc_clear) begin
      tap <= '0;
      acc <= '0;
    end else if (tap_valid) begin
      tap <= tap + 1'b1;
      acc <= acc + prod;  // 9 terms max, no overflow in 20 bits
    end
  end

  // requantize: bias at accumulator scale, shift back, relu, clamp
  always_comb begin
    biased = acc + (acc_t'(bias) <<< SHIFT);
    scaled = biased >>> SHIFT;       // arithmetic, floors negatives
    if (scaled < 0) begin
      clamped = '0;                  // relu
    end else if (scaled > 255) begin
      clamped = 8'd255;              // saturate
    end else begin
      clamped = pix_t'(scaled);
    end
  end

  always_ff @(posedge clk_40M) begin
    if (result_take) begin
      result <= clamped;  // stable through WRITE_OUT
    end
  end

endmodule

`default_nettype wire

//--- design/cbr_pkg.sv
`default_nettype none

package cbr_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // data widths
  ////////////////////////////////////////////////////////////////////////////

  typedef logic [7:0]         pix_t;   // image / output pixel, unsigned
  typedef logic signed [7:0]  wgt_t;   // kernel weight or bias
  typedef logic signed [19:0] acc_t;   // 9 products plus shifted bias
  typedef logic [15:0]        addr_t;  // byte address on the bus

  ////////////////////////////////////////////////////////////////////////////
  // memory map, one byte per location
  ////////////////////////////////////////////////////////////////////////////

  localparam addr_t WGT_BASE  = 16'd0;    // 9 weights, row-major
  localparam addr_t BIAS_ADDR = 16'd9;    // right after the weights
  localparam addr_t IMG_BASE  = 16'd16;   // 64 pixels, row-major
  localparam addr_t OUT_BASE  = 16'd128;  // 36 results, row-major

  // geometry
  localparam int IMG_DIM = 8;
  localparam int K_DIM   = 3;
  localparam int OUT_DIM = 6;             // valid conv, IMG_DIM - K_DIM + 1
  localparam int N_TAPS  = K_DIM * K_DIM;

  ////////////////////////////////////////////////////////////////////////////
  // controller states
  ////////////////////////////////////////////////////////////////////////////

  typedef enum logic [2:0] {
    IDLE,        // wait for start
    LOAD_PARAM,  // 9 weights + bias
    READ_WIN,    // 9 pixels of one window
    ACCUM_WAIT,  // last product lands, result latched
    WRITE_OUT,   // one output byte
    FINISH       // done pulse
  } ctrl_state_t;

endpackage

`default_nettype wire

//--- design/cbr_wb_if.sv
`timescale 1ns/1ps
`default_nettype none

// byte wide wishbone classic, single access in flight
interface cbr_wb_if;
  import cbr_pkg::*;

  logic  cyc;    // cycle valid
  logic  stb;    // strobe, raised with cyc
  logic  we;     // 1 = write
  addr_t adr;    // byte address
  pix_t  dat_w;  // write data
  pix_t  dat_r;  // read data, valid with ack
  logic  ack;    // slave done, may be held off for wait states

  // engine side
  modport master (
    output cyc,
    output stb,
    output we,
    output adr,
    output dat_w,
    input  dat_r,
    input  ack
  );

  // memory side
  modport slave (
    input  cyc,
    input  stb,
    input  we,
    input  adr,
    input  dat_w,
    output dat_r,
    output ack
  );

endinterface

`default_nettype wire

//--- design/conv_addr_gen.sv
`timescale 1ns/1ps
`default_nettype none

module conv_addr_gen (
  input  wire            clk_40M,
  input  wire            rst_n,
  input  wire            param_step,  // param read acked
  input  wire            tap_step,    // window read acked
  input  wire            out_step,    // result write acked
  input  wire            addr_sel,    // 0 = param, 1 = window
  output cbr_pkg::addr_t rd_addr,
  output cbr_pkg::addr_t wr_addr,
  output logic           param_last,
  output logic           tap_last,
  output logic           out_last
);
  import cbr_pkg::*;

  logic [3:0] pidx;  // 0..8 weights, 9 bias
  logic [1:0] krow;  // kernel row
  logic [1:0] kcol;  // kernel col
  logic [2:0] orow;  // output row
  logic [2:0] ocol;  // output col
  addr_t      img_row;
  addr_t      img_col;
  addr_t      win_addr;

  assign param_last = (pidx == 4'(BIAS_ADDR - WGT_BASE));
  assign tap_last   = (krow == 2'(K_DIM - 1)) && (kcol == 2'(K_DIM - 1));
  assign out_last   = (orow == 3'(OUT_DIM - 1)) && (ocol == 3'(OUT_DIM - 1));

  ////////////////////////////////////////////////////////////////////////////
  // counters, each wraps to zero at its last value
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_40M or negedge rst_n) begin
    if (!rst_n) begin
      pidx <= '0;
      krow <= '0;
      kcol <= '0;
      orow <= '0;
      ocol <= '0;
    end else begin
      if (param_step) begin
        pidx <= param_last ? '0 : pidx + 1'b1;
      end
      if (tap_step) begin  // col first, then row
        if (kcol == 2'(K_DIM - 1)) begin
          kcol <= '0;
          krow <= (krow == 2'(K_DIM - 1)) ? '0 : krow + 1'b1;
        end else begin
          kcol <= kcol + 1'b1;
        end
      end
      if (out_step) begin
        if (ocol == 3'(OUT_DIM - 1)) begin
          ocol <= '0;
          orow <= (orow == 3'(OUT_DIM - 1)) ? '0 : orow + 1'b1;
        end else begin
          ocol <= ocol + 1'b1;
        end
      end
    end
  end

  // image position = output position + tap offset
  assign img_row  = addr_t'(orow) + addr_t'(krow);
  assign img_col  = addr_t'(ocol) + addr_t'(kcol);
  assign win_addr = IMG_BASE + img_row * addr_t'(IMG_DIM) + img_col;

  assign rd_addr = addr_sel ? win_addr : WGT_BASE + addr_t'(pidx);
  assign wr_addr = OUT_BASE + addr_t'(orow) * addr_t'(OUT_DIM) + addr_t'(ocol);

endmodule

`default_nettype wire

//--- design/conv_top.sv
`timescale 1ns/1ps
`default_nettype none

module conv_top #(
  parameter int RST_CNT = 2000,
  parameter int SHIFT   = 4
) (
  input  wire                clk_40M,
  input  wire                clk_40MHz_locked,
  input  wire                start,
  output logic               busy,
  output logic               done,
  output logic               wb_cyc,
  output logic               wb_stb,
  output logic               wb_we,
  output cbr_pkg::addr_t     wb_adr,
  output cbr_pkg::pix_t      wb_dat_w,
  input  wire cbr_pkg::pix_t wb_dat_r,
  input  wire                wb_ack
);
  import cbr_pkg::*;

  logic       rst_n;        // held low RST_CNT cycles past lock
  logic       param_step;
  logic       tap_step;
  logic       out_step;
  logic       addr_sel;
  logic       param_load;
  logic [3:0] param_idx;
  logic       tap_valid;
  logic       acc_clear;
  logic       result_take;
  logic       param_last;
  logic       tap_last;
  logic       out_last;
  addr_t      rd_addr;
  addr_t      wr_addr;
  pix_t       result;

  cbr_wb_if bus ();

  // memory side of the bus out to plain ports
  assign wb_cyc    = bus.cyc;
  assign wb_stb    = bus.stb;
  assign wb_we     = bus.we;
  assign wb_adr    = bus.adr;
  assign wb_dat_w  = bus.dat_w;
  assign bus.dat_r = wb_dat_r;
  assign bus.ack   = wb_ack;

  rst_hold_timer #(
    .RST_CNT (RST_CNT)
  ) u_rst_hold_timer (
    .clk_40M          (clk_40M),
    .clk_40MHz_locked (clk_40MHz_locked),
    .rst_n            (rst_n)
  );

  conv_addr_gen u_conv_addr_gen (
    .clk_40M    (clk_40M),
    .rst_n      (rst_n),
    .param_step (param_step),
    .tap_step   (tap_step),
    .out_step   (out_step),
    .addr_sel   (addr_sel),
    .rd_addr    (rd_addr),
    .wr_addr    (wr_addr),
    .param_last (param_last),
    .tap_last   (tap_last),
    .out_last   (out_last)
  );

  cbr_ctrl u_cbr_ctrl (
    .clk_40M     (clk_40M),
    .rst_n       (rst_n),
    .start       (start),
    .busy        (busy),
    .done        (done),
    .bus         (bus),
    .param_step  (param_step),
    .tap_step    (tap_step),
    .out_step    (out_step),
    .addr_sel    (addr_sel),
    .param_load  (param_load),
    .param_idx   (param_idx),
    .tap_valid   (tap_valid),
    .acc_clear   (acc_clear),
    .result_take (result_take),
    .param_last  (param_last),
    .tap_last    (tap_last),
    .out_last    (out_last),
    .rd_addr     (rd_addr),
    .wr_addr     (wr_addr),
    .result      (result)
  );

  cbr_mac #(
    .SHIFT (SHIFT)
  ) u_cbr_mac (
    .clk_40M     (clk_40M),
    .rst_n       (rst_n),
    .param_load  (param_load),
    .param_idx   (param_idx),
    .tap_valid   (tap_valid),
    .acc_clear   (acc_clear),
    .result_take (result_take),
    .dat_r       (bus.dat_r),
    .result      (result)
  );

endmodule

`default_nettype wire

//--- design/rst_hold_timer.sv
`timescale 1ns/1ps
`default_nettype none

module rst_hold_timer #(
  parameter int RST_CNT = 2000
) (
  input  wire  clk_40M,
  input  wire  clk_40MHz_locked,
  output logic rst_n
);

  // wide enough to hold RST_CNT itself
  localparam int CW = (RST_CNT < 1) ? 1 : $clog2(RST_CNT + 1);

  logic [CW-1:0] hold_cnt;  // cycles since lock

  // saturating count, cleared while the clock is not locked
  always_ff @(posedge clk_40M or negedge clk_40MHz_locked) begin
    if (!clk_40MHz_locked) begin
      hold_cnt <= '0;
    end else if (hold_cnt != CW'(RST_CNT)) begin
      hold_cnt <= hold_cnt + 1'b1;
    end
  end

  // registered release, one edge after the count saturates
  always_ff @(posedge clk_40M or negedge clk_40MHz_locked) begin
    if (!clk_40MHz_locked) begin
      rst_n <= 1'b0;
    end else begin
      rst_n <= (hold_cnt == CW'(RST_CNT));
    end
  end

endmodule

`default_nettype wire

//--- project.f
design/cbr_pkg.sv
design/cbr_wb_if.sv
design/rst_hold_timer.sv
design/conv_addr_gen.sv
design/cbr_ctrl.sv
design/cbr_mac.sv
design/conv_top.sv
tests/tb_conv_top.sv

//--- tests/cbr_golden.txt
// per case: 9 weights, bias, 8 image rows of 8 pixels, 6 result rows of 6
// case 1 has clamped and relu'd windows, case 2 has floor rounding of a negative bias
f0 00 00 00 20 00 00 00 00
00
ff 01 02 03 04 05 06 07
10 11 12 13 14 15 16 17
20 21 22 23 24 25 26 27
30 31 32 33 fe 35 36 37
40 41 42 43 44 45 46 47
50 51 52 53 54 55 56 57
60 61 62 63 64 65 c8 67
70 71 72 73 74 75 76 77
00 23 24 25 26 27
32 33 34 35 36 37
42 43 44 ff 46 47
52 53 54 55 00 57
62 63 64 65 66 67
72 73 74 75 76 ff
08 08 08 08 08 08 08 08 08
f8
00 01 02 03 04 05 06 07
00 01 02 03 04 05 06 07
00 01 02 03 04 05 06 07
10 11 12 13 14 15 16 17
20 21 22 23 24 25 26 27
30 31 32 33 34 35 36 37
40 41 42 43 44 45 46 47
60 61 62 63 64 65 66 67
00 01 05 0a 0e 13
14 19 1d 22 26 2b
44 49 4d 52 56 5b
8c 91 95 9a 9e a3
d4 d9 dd e2 e6 eb
ff ff ff ff ff ff

//--- tests/tb_conv_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_conv_top;

  localparam int RST_CNT  = 20;
  localparam int N_RUNS   = 3;     // case 1, case 2, case 1 again with start pokes
  localparam int CASE_LEN = 110;   // 9 weights, bias, 64 pixels, 36 results
  localparam int N_ACC    = 370;   // 10 param reads, 324 window reads, 36 writes
  localparam longint WD_NS = N_RUNS * 460 * 5 * 40 + (5 + RST_CNT + 1 + 40) * 40;

  logic        clk_40M;
  logic        clk_40MHz_locked;
  logic        start;
  logic        busy;
  logic        done;
  logic        wb_cyc;
  logic        wb_stb;
  logic        wb_we;
  logic [15:0] wb_adr;
  logic [7:0]  wb_dat_w;
  logic [7:0]  wb_dat_r;
  logic        wb_ack;

  logic [7:0]  gold [CASE_LEN * 2];  // both cases back to back
  logic [7:0]  mem [256];            // byte memory seen by the engine
  logic [15:0] log_adr [$];          // every acked access in order
  logic        log_we [$];
  logic [7:0]  log_dat [$];
  integer      seed = 32'hd894e6de;
  int          errors = 0;
  int          tests_ok = 0;
  int          tests_bad = 0;
  int          cyc_n = 0;            // cycle count at posedge + 2 ns
  int          wr_cnt = 0;
  int          done_cnt = 0;
  int          done_cyc = 0;
  int          last_wr_cyc = 0;
  logic        done_busy = 1'b0;

  conv_top #(
    .RST_CNT (RST_CNT),
    .SHIFT   (4)
  ) u_conv_top (
    .clk_40M          (clk_40M),
    .clk_40MHz_locked (clk_40MHz_locked),
    .start            (start),
    .busy             (busy),
    .done             (done),
    .wb_cyc           (wb_cyc),
    .wb_stb           (wb_stb),
    .wb_we            (wb_we),
    .wb_adr           (wb_adr),
    .wb_dat_w         (wb_dat_w),
    .wb_dat_r         (wb_dat_r),
    .wb_ack           (wb_ack)
  );

  always #20 clk_40M = ~clk_40M;  // 40 ns period

  task automatic check_val(input string name, input int got, input int exp);
    if (got != exp) begin
      $display("[ERROR] %0t %s got %0h expected %0h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    if (errors == errs_before) begin
      $display("test %s: ok", name);
      tests_ok++;
    end else begin
      $display("test %s: %0d errors", name, errors - errs_before);
      tests_bad++;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // wishbone slave with 0..3 random wait states at posedge + 2 ns
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    int          wait_left;
    logic        in_access;
    logic [15:0] hold_adr;
    in_access = 1'b0;
    wait_left = 0;
    hold_adr  = '0;
    forever begin
      @(posedge clk_40M);
      #2;
      cyc_n++;
      if (wb_ack) begin
        wb_ack    = 1'b0;
        in_access = 1'b0;
        if (wb_cyc) begin
          $display("master started an access in the cycle after ack at %0t", $time);
          errors++;
        end
      end else if (wb_cyc && wb_stb) begin
        check_val("busy during access", busy, 1);
        if (!in_access) begin
          in_access = 1'b1;
          wait_left = $random(seed) & 3;
          hold_adr  = wb_adr;
        end else begin
          check_val("wb_adr held", wb_adr, hold_adr);
        end
        if (wait_left == 0) begin
          if (wb_we) begin
            mem[wb_adr[7:0]] = wb_dat_w;
            last_wr_cyc = cyc_n;  // ack cycle of this write
            wr_cnt++;
          end else begin
            wb_dat_r = mem[wb_adr[7:0]];
          end
          log_adr.push_back(wb_adr);
          log_we.push_back(wb_we);
          log_dat.push_back(wb_we ? wb_dat_w : wb_dat_r);
          wb_ack = 1'b1;
        end else begin
          wait_left--;
        end
      end
      if (done) begin
        done_cnt++;
        done_cyc  = cyc_n;
        done_busy = busy;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // one run of a golden case
  ////////////////////////////////////////////////////////////////////////////

  task automatic load_case(input int k);
    int base;
    base = k * CASE_LEN;
    for (int a = 0; a < 256; a++) begin
      mem[a] = 8'(a) ^ 8'hc3;  // background that differs per address
    end
    for (int i = 0; i < 10; i++) begin
      mem[i] = gold[base + i];  // weights then bias
    end
    for (int i = 0; i < 64; i++) begin
      mem[16 + i] = gold[base + 10 + i];
    end
  endtask

  task automatic pulse_start();
    @(posedge clk_40M);
    #2 start = 1'b1;
    @(posedge clk_40M);
    #2 start = 1'b0;
  endtask

  task automatic run_case(input int k, input bit poke);
    int d0;
    int w;
    int base;
    base = k * CASE_LEN;
    load_case(k);
    log_adr.delete();
    log_we.delete();
    log_dat.delete();
    d0 = done_cnt;
    wr_cnt = 0;
    pulse_start();
    if (poke) begin
      repeat (25) @(posedge clk_40M);  // early in the run
      pulse_start();
      wait (wr_cnt >= 12);
      pulse_start();
    end
    wait (done_cnt != d0);
    repeat (4) @(posedge clk_40M);  // room for a stray second done
    #2;
    check_val("access count", log_adr.size(), N_ACC);
    for (int i = 0; i < 10 && i < log_adr.size(); i++) begin
      check_val("param wb_adr", log_adr[i], i);
      check_val("param wb_we", log_we[i], 0);
    end
    w = 0;
    foreach (log_adr[i]) begin
      if (log_we[i]) begin
        if (w < 36) begin
          check_val("out wb_adr", log_adr[i], 128 + w);
          check_val("out wb_dat_w", log_dat[i], gold[base + 74 + w]);
        end
        w++;
      end
    end
    check_val("write count", w, 36);
    check_val("done pulses", done_cnt - d0, 1);
    check_val("done cycle", done_cyc, last_wr_cyc + 1);
    check_val("busy at done", done_busy, 0);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    int e0;
    clk_40M          = 1'b0;
    clk_40MHz_locked = 1'b0;
    start            = 1'b0;
    wb_ack           = 1'b0;
    wb_dat_r         = '0;
    $readmemh("tests/cbr_golden.txt", gold);

    // lock low for 5 cycles and then idle well past the hold time
    e0 = errors;
    for (int i = 0; i < 5 + RST_CNT + 20; i++) begin
      @(posedge clk_40M);
      #2;
      if (i == 4) begin
        clk_40MHz_locked = 1'b1;
      end
      check_val("wb_cyc", wb_cyc, 0);
      check_val("wb_stb", wb_stb, 0);
      check_val("wb_we", wb_we, 0);
      check_val("busy", busy, 0);
      check_val("done", done, 0);
    end
    check_val("accesses before start", log_adr.size(), 0);
    report_test("reset", e0);

    e0 = errors;
    run_case(0, 1'b0);
    report_test("case 1", e0);

    e0 = errors;
    run_case(1, 1'b0);  // restart with new data
    report_test("case 2", e0);

    e0 = errors;
    run_case(0, 1'b1);
    report_test("start while busy", e0);

    $display("tests passed %0d failed %0d", tests_ok, tests_bad);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

  // watchdog
  initial begin
    #(WD_NS);
    $display("timeout, the engine did not finish its runs in time");
    $display("TEST FAIL");
    $finish;
  end

endmodule

`default_nettype wire
